// ==== rtl/txCtrlPkg.sv ====
/*
  Shared types and default widths of the transmit controller.
  State encoding is kept stable because txMainState is read by debug tools.
*/
`default_nettype none

package txCtrlPkg;

  //////////////////////////////////////////////////////////////
  // main FSM states
  //////////////////////////////////////////////////////////////

  // 4-bit encoding, value 11 stays unused
  typedef enum logic [3:0] {
    Idle           = 4'd0,
    WaitSifsOrSlot = 4'd1,
    TxAmpduDlm     = 4'd2,
    TxFrame        = 4'd3,
    WaitHdToggle   = 4'd4,
    TxAmpduPad     = 4'd5,
    TxCfend        = 4'd6,
    TxRts          = 4'd7,
    TxCts          = 4'd8,
    TxAck          = 4'd9,
    TxBack         = 4'd10,
    TxWaitEnd      = 4'd12
  } txState_e;

  //////////////////////////////////////////////////////////////
  // header descriptor kind
  //////////////////////////////////////////////////////////////

  typedef logic [1:0] descKind_t;

  // first MPDU of an A-MPDU
  localparam descKind_t DescFirst = 2'b01;
  // last MPDU of an A-MPDU
  localparam descKind_t DescLast  = 2'b11;

  //////////////////////////////////////////////////////////////
  // default widths
  //////////////////////////////////////////////////////////////

  localparam int DefMpduLenWidth  = 16;
  localparam int DefBlankDlmWidth = 10;
  // low length bits that must be zero, 2 gives 4-byte alignment
  localparam int DefPadAlignBits  = 2;

endpackage

`default_nettype wire

// ==== rtl/ampduHdTracker.sv ====
/*
  Header descriptor tracking for A-MPDU transmission.
  newHdValid clears take priority over txParameterHdReady_p.
*/
`default_nettype none

module ampduHdTracker (
  // clock and resets
  input  logic                  macCoreTxClk,
  input  logic                  macCoreClkHardRst_n,
  input  logic                  macCoreTxClkSoftRst_n,
  // request and frame flags
  input  logic                  sendData_p,
  input  logic                  aMpdu,
  input  logic                  txSingleVhtMpdu,
  // MPDU progress from the FSM and the formatter
  input  logic                  sendMpdu_p,
  input  logic                  mpduDone_p,
  // descriptor cache
  input  logic                  txParameterHdReady_p,
  input  txCtrlPkg::descKind_t  whichDescriptor,
  // status to the FSM
  output logic                  newHdValid,
  output logic                  lastMpdu
);

  logic hdClear;
  logic lastCapture;

  // multi-MPDU request, MPDU launch or MPDU end consume the descriptor
  assign hdClear = (sendData_p && aMpdu && !txSingleVhtMpdu) || sendMpdu_p || mpduDone_p;

  // MPDU being launched closes the A-MPDU
  assign lastCapture = aMpdu &&
                       ((whichDescriptor == txCtrlPkg::DescLast) || txSingleVhtMpdu);

  // descriptor available flag
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      newHdValid <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      newHdValid <= 1'b0;
    else if (hdClear)
      newHdValid <= 1'b0;
    else if (txParameterHdReady_p)
      newHdValid <= 1'b1;
  end

  // last MPDU flag, sampled only when an MPDU is launched
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      lastMpdu <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      lastMpdu <= 1'b0;
    else if (sendMpdu_p)
      lastMpdu <= lastCapture;
  end

endmodule

`default_nettype wire

// ==== rtl/txMainFsm.sv ====
/*
  Main transmit FSM. Requests are taken only in Idle with exactly one high.
  Strobes are decoded from current and next state and appear with their cause.
*/
`default_nettype none

module txMainFsm #(
  parameter int MpduLenWidth  = txCtrlPkg::DefMpduLenWidth,
  parameter int BlankDlmWidth = txCtrlPkg::DefBlankDlmWidth,
  parameter int PadAlignBits  = txCtrlPkg::DefPadAlignBits
) (
  // clock and resets
  input  logic                      macCoreTxClk,
  input  logic                      macCoreClkHardRst_n,
  input  logic                      macCoreTxClkSoftRst_n,
  // send requests
  input  logic                      sendData_p,
  input  logic                      sendRts_p,
  input  logic                      sendCts_p,
  input  logic                      sendAck_p,
  input  logic                      sendCfend_p,
  input  logic                      sendBa_p,
  // frame parameters
  input  logic                      sendOnSifs,
  input  logic                      aMpdu,
  input  logic                      txSingleVhtMpdu,
  input  logic [MpduLenWidth-1:0]   mpduFrameLength,
  input  logic [BlankDlmWidth-1:0]  nBlankDelimiters,
  input  txCtrlPkg::descKind_t      whichDescriptor,
  // timer ticks
  input  logic                      tickSlot,
  input  logic                      tickSifs,
  // formatter done pulses
  input  logic                      rtsDone_p,
  input  logic                      ctsDone_p,
  input  logic                      ackDone_p,
  input  logic                      cfendDone_p,
  input  logic                      baDone_p,
  input  logic                      mpduDone_p,
  // formatter start pulses
  input  logic                      rtsTxStart_p,
  input  logic                      ctsTxStart_p,
  input  logic                      ackTxStart_p,
  input  logic                      cfendTxStart_p,
  input  logic                      baTxStart_p,
  input  logic                      mpduTxStart_p,
  // A-MPDU formatter
  input  logic                      aMpduDelimiterDone_p,
  input  logic                      aMpduPaddingDone_p,
  // PHY status
  input  logic                      mpIfTxErr_p,
  input  logic                      mpIfTxEn,
  // from the descriptor tracker
  input  logic                      newHdValid,
  input  logic                      lastMpdu,
  // formatter strobes
  output logic                      sendMpdu_p,
  output logic                      aMpduDelimiterStart_p,
  output logic                      aMpduPaddingStart_p,
  output logic                      addBlankDelimiter,
  // PHY triggers
  output logic                      startTx_p,
  output logic                      stopTx_p,
  // status
  output logic                      txDone_p,
  output txCtrlPkg::txState_e       txMainState
);

  txCtrlPkg::txState_e stateCs;
  txCtrlPkg::txState_e stateNs;
  logic                txBoundary;
  logic                padNeeded;
  logic                ampduTxStart_p;

  //////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      stateCs <= txCtrlPkg::Idle;
    else if (!macCoreTxClkSoftRst_n)
      stateCs <= txCtrlPkg::Idle;
    else
      stateCs <= stateNs;
  end

  assign txMainState = stateCs;

  // slot boundary, or SIFS boundary when asked for
  assign txBoundary = tickSlot || (sendOnSifs && tickSifs);

  // unaligned MPDU length needs pad bytes
  assign padNeeded = (mpduFrameLength[PadAlignBits-1:0] != '0);

  //////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////

  always_comb
  begin
    stateNs = stateCs;
    // PHY error aborts any frame in progress
    if (mpIfTxErr_p && (stateCs != txCtrlPkg::Idle))
      stateNs = txCtrlPkg::TxWaitEnd;
    else
    begin
      case (stateCs)
        txCtrlPkg::Idle:
        begin
          // one-hot request only, anything else stays in Idle
          case ({sendRts_p, sendCts_p, sendAck_p, sendCfend_p, sendBa_p, sendData_p})
            6'b100000: stateNs = txCtrlPkg::TxRts;
            6'b010000: stateNs = txCtrlPkg::TxCts;
            6'b001000: stateNs = txCtrlPkg::TxAck;
            6'b000100: stateNs = txCtrlPkg::TxCfend;
            6'b000010: stateNs = txCtrlPkg::TxBack;
            6'b000001:
            begin
              if (aMpdu)
                stateNs = txCtrlPkg::WaitSifsOrSlot;
              else
                stateNs = txCtrlPkg::TxFrame;
            end
            default:   stateNs = txCtrlPkg::Idle;
          endcase
        end
        txCtrlPkg::WaitSifsOrSlot:
        begin
          // single VHT MPDU already has its descriptor
          if (txBoundary)
          begin
            if (txSingleVhtMpdu)
              stateNs = txCtrlPkg::TxAmpduDlm;
            else
              stateNs = txCtrlPkg::WaitHdToggle;
          end
        end
        txCtrlPkg::WaitHdToggle:
        begin
          if (newHdValid)
            stateNs = txCtrlPkg::TxAmpduDlm;
        end
        txCtrlPkg::TxAmpduDlm:
        begin
          if (aMpduDelimiterDone_p)
            stateNs = txCtrlPkg::TxFrame;
        end
        txCtrlPkg::TxFrame:
        begin
          if (mpduDone_p)
          begin
            if (!aMpdu)
              stateNs = txCtrlPkg::TxWaitEnd;
            else if (padNeeded)
              stateNs = txCtrlPkg::TxAmpduPad;
            else if (lastMpdu)
              stateNs = txCtrlPkg::TxWaitEnd;
            else
              stateNs = txCtrlPkg::WaitHdToggle;
          end
        end
        txCtrlPkg::TxAmpduPad:
        begin
          // after padding, next descriptor or end of A-MPDU
          if (aMpduPaddingDone_p)
          begin
            if (lastMpdu)
              stateNs = txCtrlPkg::TxWaitEnd;
            else
              stateNs = txCtrlPkg::WaitHdToggle;
          end
        end
        // control frames wait for their formatter
        txCtrlPkg::TxCfend: if (cfendDone_p) stateNs = txCtrlPkg::TxWaitEnd;
        txCtrlPkg::TxRts:   if (rtsDone_p)   stateNs = txCtrlPkg::TxWaitEnd;
        txCtrlPkg::TxCts:   if (ctsDone_p)   stateNs = txCtrlPkg::TxWaitEnd;
        txCtrlPkg::TxAck:   if (ackDone_p)   stateNs = txCtrlPkg::TxWaitEnd;
        txCtrlPkg::TxBack:  if (baDone_p)    stateNs = txCtrlPkg::TxWaitEnd;
        txCtrlPkg::TxWaitEnd:
        begin
          // PHY has released the medium
          if (!mpIfTxEn)
            stateNs = txCtrlPkg::Idle;
        end
        default:
          stateNs = txCtrlPkg::Idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // strobes and PHY triggers
  //////////////////////////////////////////////////////////////

  // A-MPDU start on the PHY, first delimiter only
  assign ampduTxStart_p = (stateNs == txCtrlPkg::TxAmpduDlm) &&
                          ((stateCs == txCtrlPkg::WaitSifsOrSlot) ||
                           ((stateCs == txCtrlPkg::WaitHdToggle) &&
                            (whichDescriptor == txCtrlPkg::DescFirst)));

  assign startTx_p = rtsTxStart_p || ctsTxStart_p || ackTxStart_p || cfendTxStart_p ||
                     baTxStart_p || mpduTxStart_p || ampduTxStart_p;

  // error stops the PHY in the same cycle
  assign stopTx_p = mpIfTxErr_p;

  // MPDU launch on entry to TxFrame
  assign sendMpdu_p = (stateCs != txCtrlPkg::TxFrame) && (stateNs == txCtrlPkg::TxFrame);

  assign aMpduDelimiterStart_p = (stateNs == txCtrlPkg::TxAmpduDlm);
  assign aMpduPaddingStart_p   = (stateNs == txCtrlPkg::TxAmpduPad);
  assign addBlankDelimiter     = (stateNs == txCtrlPkg::TxAmpduDlm) && (nBlankDelimiters != '0);

  // completion one cycle after TxEn falls in TxWaitEnd
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      txDone_p <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      txDone_p <= 1'b0;
    else
      txDone_p <= (stateCs == txCtrlPkg::TxWaitEnd) && !mpIfTxEn;
  end

endmodule

`default_nettype wire

// ==== rtl/txControllerTop.sv ====
/*
  Transmit controller top. Widths are set here and passed down.
  PadAlignBits must be at least 1 and below MpduLenWidth.
*/
`default_nettype none

module txControllerTop #(
  parameter int MpduLenWidth  = txCtrlPkg::DefMpduLenWidth,
  parameter int BlankDlmWidth = txCtrlPkg::DefBlankDlmWidth,
  parameter int PadAlignBits  = txCtrlPkg::DefPadAlignBits
) (
  // clock and resets
  input  logic                      macCoreTxClk,
  input  logic                      macCoreClkHardRst_n,
  input  logic                      macCoreTxClkSoftRst_n,
  // send requests
  input  logic                      sendData_p,
  input  logic                      sendRts_p,
  input  logic                      sendCts_p,
  input  logic                      sendAck_p,
  input  logic                      sendCfend_p,
  input  logic                      sendBa_p,
  // frame parameters
  input  logic                      sendOnSifs,
  input  logic                      aMpdu,
  input  logic                      txSingleVhtMpdu,
  input  logic [MpduLenWidth-1:0]   mpduFrameLength,
  input  logic [BlankDlmWidth-1:0]  nBlankDelimiters,
  input  txCtrlPkg::descKind_t      whichDescriptor,
  input  logic                      txParameterHdReady_p,
  // timer ticks
  input  logic                      tickSlot,
  input  logic                      tickSifs,
  // formatter done pulses
  input  logic                      rtsDone_p,
  input  logic                      ctsDone_p,
  input  logic                      ackDone_p,
  input  logic                      cfendDone_p,
  input  logic                      baDone_p,
  input  logic                      mpduDone_p,
  // formatter start pulses
  input  logic                      rtsTxStart_p,
  input  logic                      ctsTxStart_p,
  input  logic                      ackTxStart_p,
  input  logic                      cfendTxStart_p,
  input  logic                      baTxStart_p,
  input  logic                      mpduTxStart_p,
  // A-MPDU formatter
  input  logic                      aMpduDelimiterDone_p,
  input  logic                      aMpduPaddingDone_p,
  // PHY status
  input  logic                      mpIfTxErr_p,
  input  logic                      mpIfTxEn,
  // formatter strobes
  output logic                      sendMpdu_p,
  output logic                      aMpduDelimiterStart_p,
  output logic                      aMpduPaddingStart_p,
  output logic                      addBlankDelimiter,
  // PHY triggers
  output logic                      startTx_p,
  output logic                      stopTx_p,
  // status and debug
  output logic                      txDone_p,
  output txCtrlPkg::txState_e       txMainState
);

  // tracker to FSM
  logic newHdValid;
  logic lastMpdu;

  //////////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////////

  txMainFsm #(
    .MpduLenWidth  (MpduLenWidth),
    .BlankDlmWidth (BlankDlmWidth),
    .PadAlignBits  (PadAlignBits)
  ) txMainFsm_i (
    .macCoreTxClk,
    .macCoreClkHardRst_n,
    .macCoreTxClkSoftRst_n,
    .sendData_p,
    .sendRts_p,
    .sendCts_p,
    .sendAck_p,
    .sendCfend_p,
    .sendBa_p,
    .sendOnSifs,
    .aMpdu,
    .txSingleVhtMpdu,
    .mpduFrameLength,
    .nBlankDelimiters,
    .whichDescriptor,
    .tickSlot,
    .tickSifs,
    .rtsDone_p,
    .ctsDone_p,
    .ackDone_p,
    .cfendDone_p,
    .baDone_p,
    .mpduDone_p,
    .rtsTxStart_p,
    .ctsTxStart_p,
    .ackTxStart_p,
    .cfendTxStart_p,
    .baTxStart_p,
    .mpduTxStart_p,
    .aMpduDelimiterDone_p,
    .aMpduPaddingDone_p,
    .mpIfTxErr_p,
    .mpIfTxEn,
    .newHdValid,
    .lastMpdu,
    .sendMpdu_p,
    .aMpduDelimiterStart_p,
    .aMpduPaddingStart_p,
    .addBlankDelimiter,
    .startTx_p,
    .stopTx_p,
    .txDone_p,
    .txMainState
  );

  //////////////////////////////////////////////////////////////
  // header descriptor tracker
  //////////////////////////////////////////////////////////////

  ampduHdTracker ampduHdTracker_i (
    .macCoreTxClk,
    .macCoreClkHardRst_n,
    .macCoreTxClkSoftRst_n,
    .sendData_p,
    .aMpdu,
    .txSingleVhtMpdu,
    .sendMpdu_p,
    .mpduDone_p,
    .txParameterHdReady_p,
    .whichDescriptor,
    .newHdValid,
    .lastMpdu
  );

endmodule

`default_nettype wire

// ==== bench/tbChecks.svh ====
/*
  Compare and abort tasks for the transmit controller testbench.
  Expects testName to be declared in the including module.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////////////////////////////////////
// run abort
//////////////////////////////////////////////////////////////

// stops at the first error
task automatic abortRun();
  $display("FAIL: see errors above");
  $fatal(1, "testbench stopped on error");
endtask

// a wait loop ran out of cycles
task automatic reportTimeout(input string what);
  $display("test %s timed out while waiting for %s", testName, what);
  abortRun();
endtask

//////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////

// debug state of the main FSM
task automatic checkState(input string what, input txCtrlPkg::txState_e exp,
                          input txCtrlPkg::txState_e act);
  if (exp !== act)
  begin
    $display("FAILED %s %s: expected %s (%0d) actual %s (%0d)",
             testName, what, exp.name(), exp, act.name(), act);
    abortRun();
  end
endtask

// single strobe in one cycle
task automatic checkPulse(input string what, input bit exp, input logic act);
  if (act !== exp)
  begin
    $display("FAILED %s %s: expected %b actual %b", testName, what, exp, act);
    abortRun();
  end
endtask

// pulse count over a whole frame
task automatic checkCount(input string what, input int exp, input int act);
  if (exp != act)
  begin
    $display("FAILED %s %s: expected %0d actual %0d", testName, what, exp, act);
    abortRun();
  end
endtask

`endif

// ==== bench/tbTxController.sv ====
/*
  Testbench of the transmit controller, scenarios come from bench/txCtrlStim.txt.
  Formatter and PHY are modelled in line with random delays, at most 3 MPDUs per test.
*/
`default_nettype none

module tbTxController;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MpduLenWidth  = txCtrlPkg::DefMpduLenWidth;
  localparam int BlankDlmWidth = txCtrlPkg::DefBlankDlmWidth;
  localparam int PadAlignBits  = txCtrlPkg::DefPadAlignBits;
  localparam int CycleLimit    = 400;

  // DUT inputs
  logic macCoreTxClk, macCoreClkHardRst_n, macCoreTxClkSoftRst_n;
  logic sendData_p, sendRts_p, sendCts_p, sendAck_p, sendCfend_p, sendBa_p;
  logic sendOnSifs, aMpdu, txSingleVhtMpdu, txParameterHdReady_p;
  logic [MpduLenWidth-1:0]  mpduFrameLength;
  logic [BlankDlmWidth-1:0] nBlankDelimiters;
  txCtrlPkg::descKind_t     whichDescriptor;
  logic tickSlot, tickSifs;
  logic rtsDone_p, ctsDone_p, ackDone_p, cfendDone_p, baDone_p, mpduDone_p;
  logic rtsTxStart_p, ctsTxStart_p, ackTxStart_p, cfendTxStart_p, baTxStart_p, mpduTxStart_p;
  logic aMpduDelimiterDone_p, aMpduPaddingDone_p, mpIfTxErr_p, mpIfTxEn;
  // DUT outputs
  logic sendMpdu_p, aMpduDelimiterStart_p, aMpduPaddingStart_p, addBlankDelimiter;
  logic startTx_p, stopTx_p, txDone_p;
  txCtrlPkg::txState_e txMainState;

  // current scenario record
  string testName;
  int    kind, isAmpdu, isVht, onSifs, nMpdu, nBlank, errCycle;
  int    lenTab[3];
  int    descTab[3];
  // start, sendMpdu, delimiter, padding, done
  int    expCnt[5];
  int    gotCnt[5];
  int unsigned rngState;

  `include "tbChecks.svh"

  txControllerTop #(
    .MpduLenWidth  (MpduLenWidth),
    .BlankDlmWidth (BlankDlmWidth),
    .PadAlignBits  (PadAlignBits)
  ) dut_i (.*);

  initial
  begin
    macCoreTxClk = 1'b0;
    forever #4 macCoreTxClk = ~macCoreTxClk;
  end

  // xorshift32 step
  function automatic int unsigned nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // model delay of 1 to 3 cycles
  function automatic int randDelay();
    return int'(nextRand() % 3) + 1;
  endfunction

  task automatic clearPulses();
    {sendData_p, sendRts_p, sendCts_p, sendAck_p, sendCfend_p, sendBa_p} = '0;
    {rtsDone_p, ctsDone_p, ackDone_p, cfendDone_p, baDone_p, mpduDone_p} = '0;
    {rtsTxStart_p, ctsTxStart_p, ackTxStart_p, cfendTxStart_p} = '0;
    {baTxStart_p, mpduTxStart_p, aMpduDelimiterDone_p, aMpduPaddingDone_p} = '0;
    {tickSlot, tickSifs, txParameterHdReady_p, mpIfTxErr_p} = '0;
  endtask

  // request of the scenario, kind 6 raises two at once
  task automatic issueRequest();
    case (kind)
      0: sendData_p = 1'b1;
      1: sendRts_p = 1'b1;
      2: sendCts_p = 1'b1;
      3: sendAck_p = 1'b1;
      4: sendCfend_p = 1'b1;
      5: sendBa_p = 1'b1;
      default:
      begin
        sendRts_p = 1'b1;
        sendCts_p = 1'b1;
      end
    endcase
  endtask

  // formatter model answer for the state it serves
  task automatic pulseFormatter(input txCtrlPkg::txState_e st, input bit isStart);
    case (st)
      txCtrlPkg::TxRts:      if (isStart) rtsTxStart_p = 1'b1; else rtsDone_p = 1'b1;
      txCtrlPkg::TxCts:      if (isStart) ctsTxStart_p = 1'b1; else ctsDone_p = 1'b1;
      txCtrlPkg::TxAck:      if (isStart) ackTxStart_p = 1'b1; else ackDone_p = 1'b1;
      txCtrlPkg::TxCfend:    if (isStart) cfendTxStart_p = 1'b1; else cfendDone_p = 1'b1;
      txCtrlPkg::TxBack:     if (isStart) baTxStart_p = 1'b1; else baDone_p = 1'b1;
      txCtrlPkg::TxFrame:    if (isStart) mpduTxStart_p = 1'b1; else mpduDone_p = 1'b1;
      txCtrlPkg::TxAmpduDlm: aMpduDelimiterDone_p = 1'b1;
      txCtrlPkg::TxAmpduPad: aMpduPaddingDone_p = 1'b1;
      default: ;
    endcase
  endtask

  function automatic bit isWorkState(input txCtrlPkg::txState_e st);
    return st inside {txCtrlPkg::TxRts, txCtrlPkg::TxCts, txCtrlPkg::TxAck,
                      txCtrlPkg::TxCfend, txCtrlPkg::TxBack, txCtrlPkg::TxFrame,
                      txCtrlPkg::TxAmpduDlm, txCtrlPkg::TxAmpduPad};
  endfunction

  //////////////////////////////////////////////////////////////
  // one scenario, cycle by cycle
  //////////////////////////////////////////////////////////////

  task automatic runFrame();
    txCtrlPkg::txState_e st;
    txCtrlPkg::txState_e lastSt;
    txCtrlPkg::txState_e dState;
    int cyc;
    int idx;
    int doneDelay;
    int endDelay;
    int sifsCnt;
    bit finished;
    bit prevWaitLow;
    bit dStart, dDone, dSifs, dSlot, dHd, dStray, txEnNext;
    bit expWaitEnd, sifsIgnored, strayIgnored, strayDone;
    lastSt = txCtrlPkg::Idle;
    dState = txCtrlPkg::Idle;
    {finished, prevWaitLow, dStart, dDone, dSifs, dSlot, dHd, dStray} = '0;
    {expWaitEnd, sifsIgnored, strayIgnored, strayDone} = '0;
    txEnNext = 1'b0;
    {idx, doneDelay, endDelay, sifsCnt} = '0;
    gotCnt = '{default: 0};
    // first MPDU parameters are valid with the request
    mpduFrameLength = lenTab[0][MpduLenWidth-1:0];
    whichDescriptor = txCtrlPkg::descKind_t'(descTab[0]);
    for (cyc = 1; (cyc <= CycleLimit) && !finished; cyc++)
    begin
      @(posedge macCoreTxClk);
      #1;
      clearPulses();
      if (cyc == 1)
        issueRequest();
      if (dStart)
        pulseFormatter(dState, 1'b1);
      if (dDone)
        pulseFormatter(dState, 1'b0);
      tickSifs = dSifs;
      tickSlot = dSlot;
      sendAck_p = sendAck_p | dStray;
      if (dHd)
      begin
        // next descriptor comes from the cache
        txParameterHdReady_p = 1'b1;
        whichDescriptor = txCtrlPkg::descKind_t'(descTab[idx]);
        mpduFrameLength = lenTab[idx][MpduLenWidth-1:0];
        idx++;
      end
      mpIfTxErr_p = (cyc == errCycle);
      mpIfTxEn = txEnNext;
      #5;
      ///////////////////////////////////////////////////////////
      // sample and check
      ///////////////////////////////////////////////////////////
      st = txMainState;
      checkPulse("txDone timing", prevWaitLow, txDone_p);
      checkPulse("stopTx with error", cyc == errCycle, stopTx_p);
      // control and singleton frames start only with their formatter
      if (isAmpdu == 0)
        checkPulse("startTx with formatter start", dStart, startTx_p);
      if (expWaitEnd)
        checkState("state after error", txCtrlPkg::TxWaitEnd, st);
      if (sifsIgnored || strayIgnored)
        checkState("request or tick ignored", lastSt, st);
      if ((kind == 0) && (cyc == 1))
        checkPulse("sendMpdu with request", isAmpdu == 0, sendMpdu_p);
      if (kind == 6)
        checkState("double request", txCtrlPkg::Idle, st);
      // no delimiter before the chosen boundary tick
      if ((st == txCtrlPkg::WaitSifsOrSlot) && !dSlot && !(dSifs && (onSifs != 0)))
        checkPulse("delimiter before tick", 1'b0, aMpduDelimiterStart_p);
      if (aMpduDelimiterStart_p)
        checkPulse("addBlankDelimiter", nBlank != 0, addBlankDelimiter);
      expWaitEnd   = (cyc == errCycle) && (st != txCtrlPkg::Idle);
      sifsIgnored  = dSifs && (onSifs == 0);
      strayIgnored = dStray;
      // pulse counts, held strobes counted on entry only
      if (startTx_p)
      begin
        gotCnt[0]++;
        txEnNext = 1'b1;
      end
      if (sendMpdu_p)
        gotCnt[1]++;
      if (aMpduDelimiterStart_p && (st != txCtrlPkg::TxAmpduDlm))
        gotCnt[2]++;
      if (aMpduPaddingStart_p && (st != txCtrlPkg::TxAmpduPad))
        gotCnt[3]++;
      if (txDone_p)
      begin
        gotCnt[4]++;
        checkState("state after done", txCtrlPkg::Idle, st);
        finished = 1'b1;
      end
      if ((kind == 6) && (cyc == 6))
        finished = 1'b1;
      prevWaitLow = (st == txCtrlPkg::TxWaitEnd) && !mpIfTxEn;
      ///////////////////////////////////////////////////////////
      // models decide the next cycle
      ///////////////////////////////////////////////////////////
      {dStart, dDone, dSifs, dSlot, dHd, dStray} = '0;
      if (st != lastSt)
      begin
        if (isWorkState(st))
        begin
          doneDelay = randDelay();
          dState = st;
          // A-MPDU start is made inside the DUT
          dStart = (st != txCtrlPkg::TxAmpduDlm) && (st != txCtrlPkg::TxAmpduPad) &&
                   !((st == txCtrlPkg::TxFrame) && (isAmpdu != 0));
        end
        if (st == txCtrlPkg::WaitSifsOrSlot)
          sifsCnt = 0;
        if (st == txCtrlPkg::WaitHdToggle)
          dHd = 1'b1;
        if (st == txCtrlPkg::TxWaitEnd)
          endDelay = randDelay();
      end
      else if (isWorkState(st) && (doneDelay > 0))
      begin
        doneDelay--;
        if (doneDelay == 0)
        begin
          dDone = 1'b1;
          dState = st;
        end
      end
      // SIFS tick first, slot tick one cycle later
      if (st == txCtrlPkg::WaitSifsOrSlot)
      begin
        sifsCnt++;
        dSifs = (sifsCnt == 2);
        dSlot = (sifsCnt == 3);
      end
      // PHY drops TxEn some cycles into TxWaitEnd
      if ((st == txCtrlPkg::TxWaitEnd) && mpIfTxEn)
      begin
        if (endDelay > 0)
          endDelay--;
        if (endDelay == 0)
          txEnNext = 1'b0;
        else if (!strayDone)
        begin
          dStray = 1'b1;
          strayDone = 1'b1;
        end
      end
      lastSt = st;
    end
    if (!finished)
      reportTimeout("txDone_p");
    checkCount("startTx count", expCnt[0], gotCnt[0]);
    if (expCnt[1] >= 0)
      checkCount("sendMpdu count", expCnt[1], gotCnt[1]);
    if (expCnt[2] >= 0)
      checkCount("delimiter start count", expCnt[2], gotCnt[2]);
    if (expCnt[3] >= 0)
      checkCount("padding start count", expCnt[3], gotCnt[3]);
    checkCount("txDone count", expCnt[4], gotCnt[4]);
  endtask

  // short gap between scenarios, Idle expected
  task automatic waitIdle();
    int n;
    n = 0;
    while (txMainState != txCtrlPkg::Idle)
    begin
      @(posedge macCoreTxClk);
      n++;
      if (n > 20)
        reportTimeout("Idle between tests");
    end
    repeat (2) @(posedge macCoreTxClk);
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////

  initial
  begin
    int    fd;
    int    nRead;
    int    nTests;
    string line;
    rngState = 32'h5443_64df;
    macCoreClkHardRst_n = 1'b0;
    macCoreTxClkSoftRst_n = 1'b0;
    clearPulses();
    {sendOnSifs, aMpdu, txSingleVhtMpdu, mpIfTxEn} = '0;
    mpduFrameLength = '0;
    nBlankDelimiters = '0;
    whichDescriptor = '0;
    testName = "reset";
    nTests = 0;
    repeat (3) @(posedge macCoreTxClk);
    #1;
    macCoreClkHardRst_n = 1'b1;
    macCoreTxClkSoftRst_n = 1'b1;
    fd = $fopen("bench/txCtrlStim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file bench/txCtrlStim.txt");
      abortRun();
    end
    while (!$feof(fd))
    begin
      line = "";
      nRead = $fgets(line, fd);
      if ((nRead == 0) || (line.len() < 2) || (line.substr(0, 0) == "#"))
        continue;
      nRead = $sscanf(line, "%s %d %d %d %d %d %h %h %h %d %d %d %d %d %d %d %d %d %d",
                      testName, kind, isAmpdu, isVht, onSifs, nMpdu,
                      lenTab[0], lenTab[1], lenTab[2], descTab[0], descTab[1], descTab[2],
                      nBlank, errCycle, expCnt[0], expCnt[1], expCnt[2], expCnt[3],
                      expCnt[4]);
      if (nRead != 19)
      begin
        $display("malformed stimulus record: %s", line);
        abortRun();
      end
      waitIdle();
      #1;
      aMpdu = (isAmpdu != 0);
      txSingleVhtMpdu = (isVht != 0);
      sendOnSifs = (onSifs != 0);
      nBlankDelimiters = nBlank[BlankDlmWidth-1:0];
      runFrame();
      nTests++;
    end
    $fclose(fd);
    if (nTests == 0)
    begin
      $display("no test record found in the stimulus file");
      abortRun();
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== bench/txCtrlStim.txt ====
# name kind ampdu vht sifs nMpdu len0 len1 len2 (hex) desc0 desc1 desc2 blank errCycle
# expected: startTx sendMpdu dlmStart padStart txDone (-1 skips); kind 0 data 1..5 control 6 two
rtsOnly     1 0 0 0 0 0   0   0   0 0 0 0 0  1 0 0 0 1
ctsOnly     2 0 0 0 0 0   0   0   0 0 0 0 0  1 0 0 0 1
ackOnly     3 0 0 0 0 0   0   0   0 0 0 0 0  1 0 0 0 1
cfendOnly   4 0 0 0 0 0   0   0   0 0 0 0 0  1 0 0 0 1
baOnly      5 0 0 0 0 0   0   0   0 0 0 0 0  1 0 0 0 1
dataSingle  0 0 0 0 1 40  0   0   0 0 0 0 0  1 1 0 0 1
ampduSlot   0 1 0 0 3 40  43  81  1 2 3 0 0  1 3 3 2 1
ampduSifs   0 1 0 1 2 100 102 0   1 3 0 4 0  1 2 2 1 1
vhtBlank    0 1 1 0 1 55  0   0   3 0 0 2 0  1 1 1 1 1
vhtNoBlank  0 1 1 1 1 54  0   0   3 0 0 0 0  1 1 1 0 1
errCts      2 0 0 0 0 0   0   0   0 0 0 0 3  1 0 0 0 1
errAmpdu    0 1 0 0 3 40  44  80  1 2 3 1 14 1 -1 -1 -1 1
twoRequests 6 0 0 0 0 0   0   0   0 0 0 0 0  0 0 0 0 0

// ==== sources.f ====
+incdir+bench
rtl/txCtrlPkg.sv
rtl/ampduHdTracker.sv
rtl/txMainFsm.sv
rtl/txControllerTop.sv
bench/tbTxController.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the transmit controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tbTxController -f sources.f -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
